// File: tb.f
verilog/stm_pkg.sv
verilog/div_64_32.sv
verilog/stm_timer.sv
verilog/stm_ctl_regs.sv
verilog/stm_pattern_mem.sv
verilog/stm_top.sv
testbench/tb_clk_gen.sv
testbench/tb_stm_top.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_stm_top -f tb.f
./obj_dir/Vtb_stm_top > sim.log 2>&1
cat sim.log

if grep -q "Test failures found" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"

// File: testbench/tb_stm_top.sv
module tb_stm_top;

  import stm_pkg::*;

  localparam int DEPTH_BITS = 10;
  localparam int DEPTH = 2 ** DEPTH_BITS;
  localparam int ROUNDS = 8;
  localparam int CHECK_CYCLES = 300;
  localparam int ROUND_WRITES = 1024;
  localparam int PIPE_CYCLES = 2 * DIV_LATENCY;
  localparam int CYCLE_LIMIT = ROUNDS * (PIPE_CYCLES + CHECK_CYCLES + ROUND_WRITES) + 13000;
  localparam logic [31:0] SEED = 32'd70151;
  localparam logic [7:0] SEG_SEQ = 8'b0100_1011; // requested segment per round.

  logic        CLK;
  logic        reset;
  logic        wr_en;
  logic [15:0] wr_addr;
  logic [15:0] wr_data;
  logic [63:0] sys_time;
  logic [15:0] pattern_data;
  logic        cur_segment;
  logic [15:0] idx_0;
  logic [15:0] idx_1;
  logic        update_done;

  logic [31:0] lfsr_state;
  int          edge_num;
  int          cycle_count;
  int          checked_edges;
  int          value_errors;
  int          other_errors;

  // model of staged and latched settings.
  logic [15:0] m_cycle   [NUM_SEGMENTS];
  logic [31:0] m_fd      [NUM_SEGMENTS];
  logic [15:0] act_cycle [NUM_SEGMENTS];
  logic [31:0] act_fd    [NUM_SEGMENTS];
  logic [15:0] m_mem     [NUM_SEGMENTS][DEPTH];
  logic        exp_seg;
  logic        pend_seg;
  int          load_end;
  int          done_edge;

  logic [63:0] time_hist [$]; // sys_time as sampled, one entry per edge.
  logic        idx_on;
  logic        pat_on;
  logic [15:0] exp_word;

  tb_clk_gen u_clk_gen (
    .CLK  (CLK),
    .reset(reset)
  );

  stm_top #(
    .DEPTH_BITS(DEPTH_BITS)
  ) u_stm_top (
    .CLK         (CLK),
    .reset       (reset),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .sys_time    (sys_time),
    .pattern_data(pattern_data),
    .cur_segment (cur_segment),
    .idx_0       (idx_0),
    .idx_1       (idx_1),
    .update_done (update_done)
  );

  // galois form, taps 32 22 2 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // (time / divider) mod (cycle + 1), zero divider gives all ones.
  function automatic logic [15:0] model_index(input logic [63:0] t, input logic [31:0] fd,
                                               input logic [15:0] cyc);
    logic [63:0] q;
    logic [63:0] len;
    logic [63:0] rem;
    if (fd == 32'd0) begin
      q = '1;
    end else begin
      q = t / {32'd0, fd};
    end
    len = {48'd0, cyc} + 64'd1;
    rem = q % len;
    return rem[15:0];
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                 input logic [63:0] act_val);
    $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, exp_val, act_val);
    value_errors++;
  endtask

  task automatic final_report();
    $display("checked edges: %0d, value errors: %0d, other errors: %0d",
             checked_edges, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  task automatic check_outputs();
    logic [63:0] old_time;
    logic [15:0] exp_idx [NUM_SEGMENTS];
    logic        exp_done;
    old_time = '0;
    if (time_hist.size() == PIPE_CYCLES) begin
      old_time = time_hist.pop_front();
    end
    time_hist.push_back(sys_time);
    for (int s = 0; s < NUM_SEGMENTS; s++) begin
      exp_idx[s] = model_index(old_time, act_fd[s], act_cycle[s]);
    end
    checked_edges++;
    exp_done = (edge_num == done_edge);
    if (update_done !== exp_done) report_mismatch("update_done", 64'(exp_done), 64'(update_done));
    if (cur_segment !== exp_seg) report_mismatch("cur_segment", 64'(exp_seg), 64'(cur_segment));
    if (exp_done) idx_on = 1'b1;
    if (idx_on) begin
      if (idx_0 !== exp_idx[0]) report_mismatch("idx_0", 64'(exp_idx[0]), 64'(idx_0));
      if (idx_1 !== exp_idx[1]) report_mismatch("idx_1", 64'(exp_idx[1]), 64'(idx_1));
    end
    if (pat_on) begin
      if (pattern_data !== exp_word) begin
        report_mismatch("pattern_data", 64'(exp_word), 64'(pattern_data));
      end
    end
    // read for the next edge uses this edge's segment and index.
    pat_on   = idx_on;
    exp_word = m_mem[exp_seg][exp_idx[exp_seg][DEPTH_BITS-1:0]];
    if (exp_done) exp_seg = pend_seg;
  endtask

  task automatic next_edge();
    @(posedge CLK);
    edge_num++;
    check_outputs();
    wr_en    <= 1'b0;
    sys_time <= sys_time + 64'd1;
  endtask

  task automatic host_write(input logic [15:0] addr, input logic [15:0] data);
    next_edge();
    wr_en   <= 1'b1;
    wr_addr <= addr;
    wr_data <= data;
  endtask

  task automatic write_reg(input stm_reg_t sel, input logic [15:0] data);
    host_write({13'd0, sel}, data);
    case (sel)
      reg_cycle_0:       m_cycle[0] = data;
      reg_cycle_1:       m_cycle[1] = data;
      reg_freq_div_0_lo: m_fd[0][15:0] = data;
      reg_freq_div_0_hi: m_fd[0][31:16] = data;
      reg_freq_div_1_lo: m_fd[1][15:0] = data;
      reg_freq_div_1_hi: m_fd[1][31:16] = data;
      default: ;
    endcase
  endtask

  task automatic write_word(input logic seg, input int addr, input logic [15:0] data);
    host_write({1'b1, seg, 14'(addr)}, data);
    m_mem[seg][addr] = data;
  endtask

  task automatic write_ctl(input logic seg);
    int e0;
    host_write({13'd0, reg_ctl}, {15'd0, seg});
    e0 = edge_num + 1; // edge that samples the request.
    if (e0 > load_end) begin
      for (int s = 0; s < NUM_SEGMENTS; s++) begin
        act_cycle[s] = m_cycle[s];
        act_fd[s]    = m_fd[s];
      end
      pend_seg  = seg;
      load_end  = e0 + PIPE_CYCLES;
      done_edge = load_end + 1;
    end
  endtask

  task automatic random_writes(input int n);
    logic        seg;
    int          addr;
    logic [15:0] data;
    for (int i = 0; i < n; i++) begin
      seg  = rand_bits(1) != 0;
      addr = int'(rand_bits(DEPTH_BITS));
      data = 16'(rand_bits(16));
      write_word(seg, addr, data);
    end
  endtask

  task automatic load_settings();
    logic [15:0] fd;
    write_reg(reg_cycle_0, 16'(rand_bits(DEPTH_BITS))); // below memory depth.
    write_reg(reg_cycle_1, 16'(rand_bits(DEPTH_BITS)));
    fd = 16'(rand_bits(8));
    if (fd == 16'd0) fd = 16'd1;
    write_reg(reg_freq_div_0_lo, fd);
    write_reg(reg_freq_div_0_hi, 16'd0);
    fd = 16'(rand_bits(8));
    if (fd == 16'd0) fd = 16'd1;
    write_reg(reg_freq_div_1_lo, fd);
    write_reg(reg_freq_div_1_hi, 16'd0);
  endtask

  task automatic wait_done();
    next_edge();
    while (update_done !== 1'b1) next_edge();
  endtask

  task automatic check_window();
    repeat (CHECK_CYCLES - 1) next_edge();
    idx_on = 1'b0;
  endtask

  always @(posedge CLK) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      other_errors = other_errors + 1;
      final_report();
    end
  end

  initial begin
    int    gap;
    logic  seg;
    lfsr_state    = SEED;
    edge_num      = 0;
    cycle_count   = 0;
    checked_edges = 0;
    value_errors  = 0;
    other_errors  = 0;
    load_end      = -1;
    done_edge     = -1;
    exp_seg       = 1'b0;
    pend_seg      = 1'b0;
    idx_on        = 1'b0;
    pat_on        = 1'b0;
    exp_word      = '0;
    for (int s = 0; s < NUM_SEGMENTS; s++) begin
      m_cycle[s]   = '0;
      m_fd[s]      = '0;
      act_cycle[s] = '0;
      act_fd[s]    = '0;
    end
    wr_en    = 1'b0;
    wr_addr  = '0;
    wr_data  = '0;
    sys_time = rand_bits(48);

    @(posedge CLK);
    while (reset) @(posedge CLK);
    if (update_done !== 1'b0) report_mismatch("update_done", 64'd0, 64'(update_done));
    if (cur_segment !== 1'b0) report_mismatch("cur_segment", 64'd0, 64'(cur_segment));

    // fill every word of both segments.
    for (int s = 0; s < NUM_SEGMENTS; s++) begin
      for (int a = 0; a < DEPTH; a++) begin
        write_word(s[0], a, 16'(rand_bits(16)));
      end
    end

    // settings still zero from reset.
    write_ctl(1'b0);
    wait_done();
    check_window();

    for (int r = 0; r < ROUNDS; r++) begin
      random_writes(ROUND_WRITES);
      load_settings();
      seg = SEG_SEQ[r];
      write_ctl(seg);
      if (r % 2 == 1) begin
        gap = 8 + int'(rand_bits(5));
        repeat (gap) next_edge();
        write_ctl(!seg); // lands in load.
      end
      wait_done();
      check_window();
    end

    next_edge();
    final_report();
  end

endmodule

// File: testbench/tb_clk_gen.sv
module tb_clk_gen (
  output logic CLK,
  output logic reset
);

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK; // period 100.
  end

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge CLK);
    reset <= 1'b0;
  end

endmodule

// File: verilog/stm_top.sv
module stm_top #(
  parameter int DEPTH_BITS = 10
) (
  input  logic        CLK,
  input  logic        reset,
  input  logic        wr_en,
  input  logic [15:0] wr_addr,
  input  logic [15:0] wr_data,
  input  logic [63:0] sys_time,
  output logic [15:0] pattern_data,
  output logic        cur_segment,
  output logic [15:0] idx_0,
  output logic [15:0] idx_1,
  output logic        update_done
);

  logic [15:0]           cycle_0;
  logic [15:0]           cycle_1;
  logic [31:0]           freq_div_0;
  logic [31:0]           freq_div_1;
  logic                  update_req;
  logic                  mem_wr_en;
  logic                  mem_wr_seg;
  logic [DEPTH_BITS-1:0] mem_wr_addr;

  stm_ctl_regs #(
    .DEPTH_BITS(DEPTH_BITS)
  ) u_ctl_regs (
    .CLK        (CLK),
    .reset      (reset),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .update_done(update_done),
    .cycle_0    (cycle_0),
    .cycle_1    (cycle_1),
    .freq_div_0 (freq_div_0),
    .freq_div_1 (freq_div_1),
    .update_req (update_req),
    .cur_segment(cur_segment),
    .mem_wr_en  (mem_wr_en),
    .mem_wr_seg (mem_wr_seg),
    .mem_wr_addr(mem_wr_addr)
  );

  stm_timer u_timer (
    .CLK        (CLK),
    .reset      (reset),
    .update_req (update_req),
    .sys_time   (sys_time),
    .cycle_0    (cycle_0),
    .cycle_1    (cycle_1),
    .freq_div_0 (freq_div_0),
    .freq_div_1 (freq_div_1),
    .idx_0      (idx_0),
    .idx_1      (idx_1),
    .update_done(update_done)
  );

  // host data doubles as the pattern word.
  stm_pattern_mem #(
    .DEPTH_BITS(DEPTH_BITS)
  ) u_pattern_mem (
    .CLK         (CLK),
    .wr_en       (mem_wr_en),
    .wr_seg      (mem_wr_seg),
    .wr_addr     (mem_wr_addr),
    .wr_data     (wr_data),
    .cur_segment (cur_segment),
    .idx_0       (idx_0),
    .idx_1       (idx_1),
    .pattern_data(pattern_data)
  );

endmodule

// File: verilog/stm_pattern_mem.sv
module stm_pattern_mem #(
  parameter int DEPTH_BITS = 10
) (
  input  logic                  CLK,
  input  logic                  wr_en,
  input  logic                  wr_seg,
  input  logic [DEPTH_BITS-1:0] wr_addr,
  input  logic [15:0]           wr_data,
  input  logic                  cur_segment,
  input  logic [15:0]           idx_0,
  input  logic [15:0]           idx_1,
  output logic [15:0]           pattern_data
);

  import stm_pkg::*;

  localparam int DEPTH = 2 ** DEPTH_BITS;

  logic [15:0] mem [NUM_SEGMENTS][DEPTH];
  logic [DEPTH_BITS-1:0] rd_addr;

  // index of the active segment only.
  assign rd_addr = cur_segment ? idx_1[DEPTH_BITS-1:0] : idx_0[DEPTH_BITS-1:0];

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_seg][wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge CLK) begin
    pattern_data <= mem[cur_segment][rd_addr]; // old word on a same-cycle write.
  end

endmodule

// File: verilog/stm_ctl_regs.sv
module stm_ctl_regs #(
  parameter int DEPTH_BITS = 10
) (
  input  logic                  CLK,
  input  logic                  reset,
  input  logic                  wr_en,
  input  logic [15:0]           wr_addr,
  input  logic [15:0]           wr_data,
  input  logic                  update_done,
  output logic [15:0]           cycle_0,
  output logic [15:0]           cycle_1,
  output logic [31:0]           freq_div_0,
  output logic [31:0]           freq_div_1,
  output logic                  update_req,
  output logic                  cur_segment,
  output logic                  mem_wr_en,
  output logic                  mem_wr_seg,
  output logic [DEPTH_BITS-1:0] mem_wr_addr
);

  import stm_pkg::*;

  stm_reg_t reg_sel;
  logic     reg_wr;
  logic     pending_segment;
  logic     busy; // mirrors the timer load phase.
  logic     req_accept;

  assign reg_sel = stm_reg_t'(wr_addr[2:0]);
  assign reg_wr  = wr_en && !wr_addr[15];

  // bit 15 selects the pattern memory.
  assign mem_wr_en   = wr_en && wr_addr[15];
  assign mem_wr_seg  = wr_addr[14];
  assign mem_wr_addr = wr_addr[DEPTH_BITS-1:0];

  assign update_req = reg_wr && (reg_sel == reg_ctl);

  // timer takes a request when idle, also on its done cycle.
  assign req_accept = update_req && (!busy || update_done);

  always_ff @(posedge CLK) begin
    if (reset) begin
      cycle_0    <= '0;
      cycle_1    <= '0;
      freq_div_0 <= '0;
      freq_div_1 <= '0;
    end else if (reg_wr) begin
      case (reg_sel)
        reg_cycle_0:       cycle_0 <= wr_data;
        reg_cycle_1:       cycle_1 <= wr_data;
        reg_freq_div_0_lo: freq_div_0[15:0] <= wr_data;
        reg_freq_div_0_hi: freq_div_0[31:16] <= wr_data;
        reg_freq_div_1_lo: freq_div_1[15:0] <= wr_data;
        reg_freq_div_1_hi: freq_div_1[31:16] <= wr_data;
        default: ; // ctl handled below.
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      pending_segment <= 1'b0;
      cur_segment     <= 1'b0;
      busy            <= 1'b0;
    end else begin
      if (update_done) begin
        cur_segment <= pending_segment;
      end
      if (req_accept) begin
        pending_segment <= wr_data[0];
        busy            <= 1'b1;
      end else if (update_done) begin
        busy <= 1'b0;
      end
    end
  end

endmodule

// File: verilog/stm_timer.sv
module stm_timer (
  input  logic        CLK,
  input  logic        reset,
  input  logic        update_req,
  input  logic [63:0] sys_time,
  input  logic [15:0] cycle_0,
  input  logic [15:0] cycle_1,
  input  logic [31:0] freq_div_0,
  input  logic [31:0] freq_div_1,
  output logic [15:0] idx_0,
  output logic [15:0] idx_1,
  output logic        update_done
);

  import stm_pkg::*;

  localparam int LOAD_CYCLES = 2 * DIV_LATENCY;
  localparam int CNT_BITS = $clog2(LOAD_CYCLES);

  stm_state_t state;
  logic [CNT_BITS-1:0] cnt;

  logic [15:0] cycle_in    [NUM_SEGMENTS];
  logic [31:0] freq_div_in [NUM_SEGMENTS];

  // latched settings, cycle stored as length plus one.
  logic [31:0] cycle_q    [NUM_SEGMENTS];
  logic [31:0] freq_div_q [NUM_SEGMENTS];

  logic [15:0] idx [NUM_SEGMENTS];

  assign cycle_in[0]    = cycle_0;
  assign cycle_in[1]    = cycle_1;
  assign freq_div_in[0] = freq_div_0;
  assign freq_div_in[1] = freq_div_1;

  assign idx_0 = idx[0];
  assign idx_1 = idx[1];

  // time / freq_div, then that quotient mod (cycle + 1).
  for (genvar s = 0; s < NUM_SEGMENTS; s++) begin : g_seg
    logic [63:0] quo;
    logic [31:0] rem;

    div_64_32 u_div_time (
      .CLK      (CLK),
      .dividend (sys_time),
      .divisor  (freq_div_q[s]),
      .quotient (quo),
      .remainder()
    );

    div_64_32 u_div_cycle (
      .CLK      (CLK),
      .dividend (quo),
      .divisor  (cycle_q[s]),
      .quotient (),
      .remainder(rem)
    );

    assign idx[s] = rem[15:0];
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      state       <= st_wait;
      cnt         <= '0;
      update_done <= 1'b0;
      for (int s = 0; s < NUM_SEGMENTS; s++) begin
        cycle_q[s]    <= 32'd1;
        freq_div_q[s] <= '0;
      end
    end else begin
      case (state)
        st_wait: begin
          update_done <= 1'b0;
          if (update_req) begin
            for (int s = 0; s < NUM_SEGMENTS; s++) begin
              cycle_q[s]    <= 32'(cycle_in[s]) + 32'd1;
              freq_div_q[s] <= freq_div_in[s];
            end
            cnt   <= '0;
            state <= st_load;
          end
        end
        st_load: begin
          // requests here are dropped.
          cnt <= cnt + 1'b1;
          if (cnt == CNT_BITS'(LOAD_CYCLES - 1)) begin // both chains flushed.
            update_done <= 1'b1;
            state       <= st_wait;
          end
        end
        default: state <= st_wait;
      endcase
    end
  end

endmodule

// File: verilog/div_64_32.sv
module div_64_32 (
  input  logic        CLK,
  input  logic [63:0] dividend,
  input  logic [31:0] divisor,
  output logic [63:0] quotient,
  output logic [31:0] remainder
);

  localparam int STAGES = 64;

  // restoring division, one quotient bit per stage.
  // stage k holds the state after k bits, stage 0 is the input register.
  logic [31:0] rem_q [STAGES+1];
  logic [63:0] dq_q  [STAGES+1]; // dividend bits leave at the top, quotient bits enter below.
  logic [31:0] dvs_q [STAGES+1];

  logic [32:0] trial [1:STAGES];
  logic [32:0] diff  [1:STAGES];
  logic        take  [1:STAGES];

  for (genvar k = 1; k <= STAGES; k++) begin : g_stage
    // shift in the next dividend bit.
    assign trial[k] = {rem_q[k-1], dq_q[k-1][63]};
    assign diff[k]  = trial[k] - {1'b0, dvs_q[k-1]};
    assign take[k]  = (trial[k] >= {1'b0, dvs_q[k-1]}); // zero divisor always takes.
  end

  always_ff @(posedge CLK) begin
    rem_q[0] <= '0;
    dq_q[0]  <= dividend;
    dvs_q[0] <= divisor;
    for (int k = 1; k <= STAGES; k++) begin
      rem_q[k] <= take[k] ? diff[k][31:0] : trial[k][31:0];
      dq_q[k]  <= {dq_q[k-1][62:0], take[k]};
      dvs_q[k] <= dvs_q[k-1];
    end
  end

  // output register.
  always_ff @(posedge CLK) begin
    quotient  <= dq_q[STAGES];
    remainder <= rem_q[STAGES];
  end

endmodule

// File: verilog/stm_pkg.sv
package stm_pkg;

  // timer settings state.
  typedef enum logic [1:0] {
    st_wait = 2'd0,
    st_load = 2'd1
  } stm_state_t;

  // host register opcodes, low bits of wr_addr.
  typedef enum logic [2:0] {
    reg_cycle_0       = 3'd0,
    reg_cycle_1       = 3'd1,
    reg_freq_div_0_lo = 3'd2,
    reg_freq_div_0_hi = 3'd3,
    reg_freq_div_1_lo = 3'd4,
    reg_freq_div_1_hi = 3'd5,
    reg_ctl           = 3'd6
  } stm_reg_t;

  // cycles from divider input to result.
  localparam int DIV_LATENCY = 66;

  localparam int NUM_SEGMENTS = 2;

endpackage
